// File: gps_corr.f
logic/gps_corr_pkg.sv
logic/channel_ctrl.sv
logic/carrier_wipeoff.sv
logic/correlator_bank.sv
logic/tracking_channel.sv
sim/tb_clock_gen.sv
sim/tb_tracking_channel.sv

// File: Bender.yml
package:
  name: gps_corr

sources:
  - logic/gps_corr_pkg.sv
  - logic/channel_ctrl.sv
  - logic/carrier_wipeoff.sv
  - logic/correlator_bank.sv
  - logic/tracking_channel.sv
  - target: test
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_tracking_channel.sv

// File: sim/tracking_vectors.txt
# quiet <cycles> | init <increment hex> | idle <cycles>
# samples <gap> <count> <value chip>... | expect <name> <i_e q_e i_p q_p i_l q_l>
quiet 6
init 0000
samples 0 8 3 1 -1 1 2 0 -4 0 1 1 0 1 -2 0 3 1
samples 0 8 1 0 -3 1 2 1 -1 0 0 0 3 1 -2 1 1 0
expect zero_increment 27 0 -9 0 -33 0
quiet 4
init 2000
samples 0 8 2 0 -1 1 3 1 1 1 -2 0 2 0 -3 1 1 0
samples 0 8 1 1 3 1 -1 0 -4 1 2 0 0 0 1 0 -2 1
expect carrier_step 5 -32 -1 -16 9 34
init 0000
samples 1 8 2 1 2 1 2 1 2 1 2 1 2 1 2 1 2 1
samples 2 8 2 1 2 1 2 1 2 1 2 1 2 1 2 1 2 1
samples 1 8 -1 0 -1 0 -1 0 -1 0 -1 0 -1 0 -1 0 -1 0
samples 3 8 -1 0 -1 0 -1 0 -1 0 -1 0 -1 0 -1 0 -1 0
expect gapped_period_one 96 0 84 0 72 0
expect gapped_period_two 48 0 42 0 36 0
idle 3
samples 0 7 3 1 3 1 3 1 3 1 3 1 3 1 3 1
init 4000
samples 0 8 1 1 2 0 -1 0 3 1 2 1 -2 1 0 0 1 1
samples 0 8 -3 0 1 0 2 1 -1 1 3 0 0 1 -2 0 2 1
expect restart_mid_period -6 30 12 -18 12 12
quiet 8

// File: sim/tb_tracking_channel.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tracking_channel;

   localparam int PERIOD_LEN   = 16;
   localparam int RESULT_DELAY = 3;
   localparam int RESULT_WAIT  = 64;
   localparam int ACC_W        = $bits(gps_corr_pkg::acc_t);
   localparam     VECTOR_FILE  = "sim/tracking_vectors.txt";

   wire                       clk;
   wire                       rst_n;
   logic                      sample_valid;
   gps_corr_pkg::sample_t     sample_val;
   logic                      code_chip;
   logic                      init_valid;
   gps_corr_pkg::phase_t      init_inc;
   wire                       init_ack;
   wire                       acc_valid;
   wire gps_corr_pkg::acc_t   i_early;
   wire gps_corr_pkg::acc_t   q_early;
   wire gps_corr_pkg::acc_t   i_prompt;
   wire gps_corr_pkg::acc_t   q_prompt;
   wire gps_corr_pkg::acc_t   i_late;
   wire gps_corr_pkg::acc_t   q_late;

   int cycle_count       = 0;
   int timeout_limit     = 100;
   int test_errors       = 0;
   int total_errors      = 0;
   int tests_run         = 0;
   int tests_failed      = 0;
   int samples_in_period = 0;

   // Results in the order i_early, q_early, i_prompt, q_prompt, i_late, q_late.
   logic [6*ACC_W-1:0] result_q [$];
   int                 result_cycle_q [$];
   int                 last_accept_q [$];

   tb_clock_gen u_clock_gen (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   tracking_channel uut (
      .clk                (clk),
      .rst_n_i            (rst_n),
      .sample_valid_i     (sample_valid),
      .sample_i           (sample_val),
      .code_chip_i        (code_chip),
      .init_valid_i       (init_valid),
      .init_carrier_inc_i (init_inc),
      .init_ack_o         (init_ack),
      .acc_valid_o        (acc_valid),
      .i_early_o          (i_early),
      .q_early_o          (q_early),
      .i_prompt_o         (i_prompt),
      .q_prompt_o         (q_prompt),
      .i_late_o           (i_late),
      .q_late_o           (q_late)
   );

   ////////////////////
   // Monitor and watchdog
   ////////////////////

   always @(negedge clk) begin
      if (rst_n && acc_valid) begin
         result_q.push_back({q_late, i_late, q_prompt, i_prompt, q_early, i_early});
         result_cycle_q.push_back(cycle_count);
      end
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > timeout_limit) begin
         $display("Run stopped after %0d cycles without reaching the end of the vectors",
                  cycle_count);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   ////////////////////
   // Checks
   ////////////////////

   task automatic compare_acc(input string test_name, input string field,
                              input gps_corr_pkg::acc_t expected,
                              input gps_corr_pkg::acc_t actual);
      if (actual !== expected) begin
         $display("MISMATCH %s %s expected %0d actual %0d", test_name, field, expected, actual);
         test_errors++;
      end
   endtask

   task automatic compare_flag(input string test_name, input string field,
                               input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("MISMATCH %s %s expected %b actual %b", test_name, field, expected, actual);
         test_errors++;
      end
   endtask

   task automatic compare_latency(input string test_name, input int expected, input int actual);
      if (actual != expected) begin
         $display("MISMATCH %s latency expected %0d actual %0d", test_name, expected, actual);
         test_errors++;
      end
   endtask

   task automatic close_test(input string test_name);
      tests_run++;
      if (test_errors == 0) begin
         $display("test %s passed", test_name);
      end else begin
         tests_failed++;
         $display("test %s failed with %0d errors", test_name, test_errors);
      end
      total_errors += test_errors;
      test_errors = 0;
   endtask

   function automatic string field_name(input int k);
      case (k)
         0:       return "i_early";
         1:       return "q_early";
         2:       return "i_prompt";
         3:       return "q_prompt";
         4:       return "i_late";
         default: return "q_late";
      endcase
   endfunction

   function automatic int count_vector_lines();
      int    fd;
      int    n;
      string line;
      n  = 0;
      fd = $fopen(VECTOR_FILE, "r");
      if (fd != 0) begin
         while ($fgets(line, fd) > 0) begin
            n++;
         end
         $fclose(fd);
      end
      return n;
   endfunction

   ////////////////////
   // Stimulus
   ////////////////////

   task automatic check_quiet(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         sample_valid = 1'b0;
         compare_flag("quiet", "init_ack_o", 1'b0, init_ack);
         compare_flag("quiet", "acc_valid_o", 1'b0, acc_valid);
      end
      close_test("quiet");
   endtask

   task automatic drive_init(input gps_corr_pkg::phase_t inc);
      string name;
      int    waited;
      name   = $sformatf("init_%h", inc);
      waited = 0;
      @(negedge clk);
      sample_valid = 1'b0;
      init_valid   = 1'b1;
      init_inc     = inc;
      compare_flag(name, "init_ack_o before request", 1'b0, init_ack);
      while (!init_ack && waited < RESULT_WAIT) begin
         @(negedge clk);
         waited++;
      end
      if (!init_ack) begin
         $display("Init request for %s was never acknowledged", name);
         test_errors++;
      end
      init_valid = 1'b0;
      // Acknowledge lasts exactly one cycle.
      @(negedge clk);
      compare_flag(name, "init_ack_o second cycle", 1'b0, init_ack);
      samples_in_period = 0;
      close_test(name);
   endtask

   task automatic drive_sample(input int value, input logic chip, input int gap);
      @(negedge clk);
      sample_valid = 1'b1;
      sample_val   = gps_corr_pkg::sample_t'(value);
      code_chip    = chip;
      samples_in_period++;
      // The sample is taken on the next rising edge.
      if (samples_in_period == PERIOD_LEN) begin
         last_accept_q.push_back(cycle_count + 1);
         samples_in_period = 0;
      end
      repeat (gap) begin
         @(negedge clk);
         sample_valid = 1'b0;
      end
   endtask

   task automatic check_result(input string name, input int expected [6]);
      logic [6*ACC_W-1:0] res;
      int                 waited;
      int                 res_cycle;
      waited = 0;
      while (result_q.size() == 0 && waited < RESULT_WAIT) begin
         @(negedge clk);
         waited++;
      end
      if (result_q.size() == 0) begin
         $display("No accumulation result arrived for test %s", name);
         test_errors++;
      end else begin
         res       = result_q.pop_front();
         res_cycle = result_cycle_q.pop_front();
         for (int k = 0; k < 6; k++) begin
            compare_acc(name, field_name(k), gps_corr_pkg::acc_t'(expected[k]),
                        gps_corr_pkg::acc_t'(res[k*ACC_W +: ACC_W]));
         end
         if (last_accept_q.size() == 0) begin
            $display("Result for test %s came before its period was complete", name);
            test_errors++;
         end else begin
            compare_latency(name, RESULT_DELAY, res_cycle - last_accept_q.pop_front());
         end
      end
      close_test(name);
   endtask

   task automatic run_vectors(input int fd);
      string cmd;
      string name;
      string rest;
      int    code;
      int    n;
      int    gap;
      int    value;
      int    chip;
      int    sums [6];
      gps_corr_pkg::phase_t inc;
      while ($fscanf(fd, "%s", cmd) == 1) begin
         if (cmd.substr(0, 0) == "#") begin
            code = $fgets(rest, fd);
         end else if (cmd == "quiet") begin
            code = $fscanf(fd, "%d", n);
            check_quiet(n);
         end else if (cmd == "init") begin
            code = $fscanf(fd, "%h", inc);
            drive_init(inc);
         end else if (cmd == "idle") begin
            code = $fscanf(fd, "%d", n);
            repeat (n) begin
               @(negedge clk);
               sample_valid = 1'b0;
            end
         end else if (cmd == "samples") begin
            code = $fscanf(fd, "%d %d", gap, n);
            for (int k = 0; k < n; k++) begin
               code = $fscanf(fd, "%d %d", value, chip);
               drive_sample(value, chip[0], gap);
            end
            @(negedge clk);
            sample_valid = 1'b0;
         end else if (cmd == "expect") begin
            code = $fscanf(fd, "%s %d %d %d %d %d %d", name,
                           sums[0], sums[1], sums[2], sums[3], sums[4], sums[5]);
            check_result(name, sums);
         end else begin
            $display("Unknown command %s in the vector file", cmd);
            total_errors++;
         end
      end
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      int fd;
      sample_valid  = 1'b0;
      sample_val    = '0;
      code_chip     = 1'b0;
      init_valid    = 1'b0;
      init_inc      = '0;
      timeout_limit = count_vector_lines() * 20 + 100;
      fd = $fopen(VECTOR_FILE, "r");
      if (fd == 0) begin
         $display("Could not open the vector file %s", VECTOR_FILE);
         total_errors++;
      end else begin
         @(posedge rst_n);
         run_vectors(fd);
         $fclose(fd);
         repeat (8) @(negedge clk);
         if (result_q.size() != 0) begin
            $display("%0d results arrived that no expect line asked for", result_q.size());
            total_errors++;
         end
      end
      $display("tests run %0d, tests failed %0d, errors %0d",
               tests_run, tests_failed, total_errors);
      if (total_errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk_o,
   output logic rst_n_o
);

   localparam int HALF_PERIOD_NS = 2;
   localparam int RESET_CYCLES   = 8;

   initial begin
      clk_o = 1'b0;
      forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
   end

   // Reset leaves on a falling edge, away from the DUT's active edge.
   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

// File: logic/tracking_channel.sv
`timescale 1ns/1ps
`default_nettype none

module tracking_channel (
   input  wire                         clk,
   input  wire                         rst_n_i,
   input  wire                         sample_valid_i,
   input  wire gps_corr_pkg::sample_t  sample_i,
   input  wire                         code_chip_i,
   input  wire                         init_valid_i,
   input  wire gps_corr_pkg::phase_t   init_carrier_inc_i,
   output wire                         init_ack_o,
   output wire                         acc_valid_o,
   output wire gps_corr_pkg::acc_t     i_early_o,
   output wire gps_corr_pkg::acc_t     q_early_o,
   output wire gps_corr_pkg::acc_t     i_prompt_o,
   output wire gps_corr_pkg::acc_t     q_prompt_o,
   output wire gps_corr_pkg::acc_t     i_late_o,
   output wire gps_corr_pkg::acc_t     q_late_o
);

   // Stage 1 carries the captured sample.
   wire                                s1_valid;
   wire gps_corr_pkg::sample_t         s1_sample;
   wire [gps_corr_pkg::NUM_TAPS-1:0]   s1_chips;
   wire                                s1_first;
   wire                                s1_last;
   wire gps_corr_pkg::phase_t          carrier_inc;
   wire                                restart;

   // Stage 2 carries the products with the carrier removed.
   wire                                s2_valid;
   wire gps_corr_pkg::baseband_t       s2_i;
   wire gps_corr_pkg::baseband_t       s2_q;
   wire [gps_corr_pkg::NUM_TAPS-1:0]   s2_chips;
   wire                                s2_first;
   wire                                s2_last;

   channel_ctrl u_channel_ctrl (
      .clk                (clk),
      .rst_n_i            (rst_n_i),
      .sample_valid_i     (sample_valid_i),
      .sample_i           (sample_i),
      .code_chip_i        (code_chip_i),
      .init_valid_i       (init_valid_i),
      .init_carrier_inc_i (init_carrier_inc_i),
      .init_ack_o         (init_ack_o),
      .s1_valid_o         (s1_valid),
      .s1_sample_o        (s1_sample),
      .s1_chips_o         (s1_chips),
      .s1_first_o         (s1_first),
      .s1_last_o          (s1_last),
      .carrier_inc_o      (carrier_inc),
      .restart_o          (restart)
   );

   carrier_wipeoff u_carrier_wipeoff (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .s1_valid_i    (s1_valid),
      .s1_sample_i   (s1_sample),
      .s1_chips_i    (s1_chips),
      .s1_first_i    (s1_first),
      .s1_last_i     (s1_last),
      .carrier_inc_i (carrier_inc),
      .restart_i     (restart),
      .s2_valid_o    (s2_valid),
      .s2_i_o        (s2_i),
      .s2_q_o        (s2_q),
      .s2_chips_o    (s2_chips),
      .s2_first_o    (s2_first),
      .s2_last_o     (s2_last)
   );

   correlator_bank u_correlator_bank (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .s2_valid_i  (s2_valid),
      .s2_i_i      (s2_i),
      .s2_q_i      (s2_q),
      .s2_chips_i  (s2_chips),
      .s2_first_i  (s2_first),
      .s2_last_i   (s2_last),
      .acc_valid_o (acc_valid_o),
      .i_early_o   (i_early_o),
      .q_early_o   (q_early_o),
      .i_prompt_o  (i_prompt_o),
      .q_prompt_o  (q_prompt_o),
      .i_late_o    (i_late_o),
      .q_late_o    (q_late_o)
   );

endmodule

`default_nettype wire

// File: logic/correlator_bank.sv
`timescale 1ns/1ps
`default_nettype none

module correlator_bank (
   input  wire                               clk,
   input  wire                               rst_n_i,
   input  wire                               s2_valid_i,
   input  wire gps_corr_pkg::baseband_t      s2_i_i,
   input  wire gps_corr_pkg::baseband_t      s2_q_i,
   input  wire [gps_corr_pkg::NUM_TAPS-1:0]  s2_chips_i,
   input  wire                               s2_first_i,
   input  wire                               s2_last_i,
   output logic                              acc_valid_o,
   output gps_corr_pkg::acc_t                i_early_o,
   output gps_corr_pkg::acc_t                q_early_o,
   output gps_corr_pkg::acc_t                i_prompt_o,
   output gps_corr_pkg::acc_t                q_prompt_o,
   output gps_corr_pkg::acc_t                i_late_o,
   output gps_corr_pkg::acc_t                q_late_o
);

   gps_corr_pkg::acc_t acc_i_q [gps_corr_pkg::NUM_TAPS];
   gps_corr_pkg::acc_t acc_q_q [gps_corr_pkg::NUM_TAPS];
   gps_corr_pkg::acc_t term_i  [gps_corr_pkg::NUM_TAPS];
   gps_corr_pkg::acc_t term_q  [gps_corr_pkg::NUM_TAPS];
   gps_corr_pkg::acc_t sum_i   [gps_corr_pkg::NUM_TAPS];
   gps_corr_pkg::acc_t sum_q   [gps_corr_pkg::NUM_TAPS];
   logic               dump_q;

   ////////////////////
   // Code wipe-off
   ////////////////////

   // Chip 1 adds, chip 0 subtracts; first sample of a period reloads.
   always_comb begin
      for (int t = 0; t < gps_corr_pkg::NUM_TAPS; t++) begin
         term_i[t] = s2_chips_i[t] ? gps_corr_pkg::acc_t'(s2_i_i)
                                   : -gps_corr_pkg::acc_t'(s2_i_i);
         term_q[t] = s2_chips_i[t] ? gps_corr_pkg::acc_t'(s2_q_i)
                                   : -gps_corr_pkg::acc_t'(s2_q_i);
         sum_i[t]  = s2_first_i ? term_i[t] : acc_i_q[t] + term_i[t];
         sum_q[t]  = s2_first_i ? term_q[t] : acc_q_q[t] + term_q[t];
      end
   end

   always_ff @(posedge clk) begin
      if (s2_valid_i) begin
         for (int t = 0; t < gps_corr_pkg::NUM_TAPS; t++) begin
            acc_i_q[t] <= sum_i[t];
            acc_q_q[t] <= sum_q[t];
         end
      end
   end

   ////////////////////
   // Result dump
   ////////////////////

   // Sums of a finished period are copied out one cycle after the last update.
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         dump_q      <= 1'b0;
         acc_valid_o <= 1'b0;
         i_early_o   <= '0;
         q_early_o   <= '0;
         i_prompt_o  <= '0;
         q_prompt_o  <= '0;
         i_late_o    <= '0;
         q_late_o    <= '0;
      end else begin
         dump_q      <= s2_valid_i && s2_last_i;
         acc_valid_o <= dump_q;
         if (dump_q) begin
            i_early_o  <= acc_i_q[gps_corr_pkg::TAP_EARLY];
            q_early_o  <= acc_q_q[gps_corr_pkg::TAP_EARLY];
            i_prompt_o <= acc_i_q[gps_corr_pkg::TAP_PROMPT];
            q_prompt_o <= acc_q_q[gps_corr_pkg::TAP_PROMPT];
            i_late_o   <= acc_i_q[gps_corr_pkg::TAP_LATE];
            q_late_o   <= acc_q_q[gps_corr_pkg::TAP_LATE];
         end
      end
   end

   flags_need_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
      (s2_first_i || s2_last_i) |-> s2_valid_i)
      else $error("period flag without a valid sample");

endmodule

`default_nettype wire

// File: logic/carrier_wipeoff.sv
`timescale 1ns/1ps
`default_nettype none

module carrier_wipeoff (
   input  wire                                clk,
   input  wire                                rst_n_i,
   input  wire                                s1_valid_i,
   input  wire gps_corr_pkg::sample_t         s1_sample_i,
   input  wire [gps_corr_pkg::NUM_TAPS-1:0]   s1_chips_i,
   input  wire                                s1_first_i,
   input  wire                                s1_last_i,
   input  wire gps_corr_pkg::phase_t          carrier_inc_i,
   input  wire                                restart_i,
   output logic                               s2_valid_o,
   output gps_corr_pkg::baseband_t            s2_i_o,
   output gps_corr_pkg::baseband_t            s2_q_o,
   output logic [gps_corr_pkg::NUM_TAPS-1:0]  s2_chips_o,
   output logic                               s2_first_o,
   output logic                               s2_last_o
);

   gps_corr_pkg::phase_t                    phase_q;
   logic [gps_corr_pkg::LUT_INDEX_BITS-1:0] lut_index;
   gps_corr_pkg::carrier_t                  cos_val;
   gps_corr_pkg::carrier_t                  sin_val;
   gps_corr_pkg::carrier_t                  q_carrier;
   gps_corr_pkg::baseband_t                 i_product;
   gps_corr_pkg::baseband_t                 q_product;

   ////////////////////
   // Carrier NCO
   ////////////////////

   // Phase advances once per valid sample, after its lookup.
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         phase_q <= '0;
      end else if (restart_i) begin
         phase_q <= '0;
      end else if (s1_valid_i) begin
         phase_q <= phase_q + carrier_inc_i;
      end
   end

   assign lut_index = phase_q[$bits(gps_corr_pkg::phase_t)-1 -: gps_corr_pkg::LUT_INDEX_BITS];

   assign cos_val = gps_corr_pkg::COS_TABLE[lut_index];
   assign sin_val = gps_corr_pkg::SIN_TABLE[lut_index];

   // Mixing sign picks the sideband.
   assign q_carrier = gps_corr_pkg::MIXING_SIGN ? -sin_val : sin_val;

   ////////////////////
   // Carrier mix
   ////////////////////

   assign i_product = gps_corr_pkg::baseband_t'(s1_sample_i)
                    * gps_corr_pkg::baseband_t'(cos_val);
   assign q_product = gps_corr_pkg::baseband_t'(s1_sample_i)
                    * gps_corr_pkg::baseband_t'(q_carrier);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         s2_valid_o <= 1'b0;
         s2_first_o <= 1'b0;
         s2_last_o  <= 1'b0;
      end else begin
         s2_valid_o <= s1_valid_i;
         s2_first_o <= s1_valid_i && s1_first_i;
         s2_last_o  <= s1_valid_i && s1_last_i;
      end
   end

   // Chips ride along with their products.
   always_ff @(posedge clk) begin
      if (s1_valid_i) begin
         s2_i_o     <= i_product;
         s2_q_o     <= q_product;
         s2_chips_o <= s1_chips_i;
      end
   end

   // Init is only taken on sample-free cycles, so the phase reset never hits a sample.
   restart_no_sample: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(restart_i && s1_valid_i))
      else $error("NCO restart collides with a valid sample");

endmodule

`default_nettype wire

// File: logic/channel_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module channel_ctrl (
   input  wire                                clk,
   input  wire                                rst_n_i,
   input  wire                                sample_valid_i,
   input  wire gps_corr_pkg::sample_t         sample_i,
   input  wire                                code_chip_i,
   input  wire                                init_valid_i,
   input  wire gps_corr_pkg::phase_t          init_carrier_inc_i,
   output logic                               init_ack_o,
   output logic                               s1_valid_o,
   output gps_corr_pkg::sample_t              s1_sample_o,
   output logic [gps_corr_pkg::NUM_TAPS-1:0]  s1_chips_o,
   output logic                               s1_first_o,
   output logic                               s1_last_o,
   output gps_corr_pkg::phase_t               carrier_inc_o,
   output logic                               restart_o
);

   logic                 init_take;
   logic [1:0]           chip_hist_q;
   gps_corr_pkg::count_t count_q;
   logic                 period_first;
   logic                 period_last;

   ////////////////////
   // Init handshake
   ////////////////////

   // An init only goes in on a cycle with no sample.
   assign init_take = init_valid_i && !sample_valid_i && !init_ack_o;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         init_ack_o    <= 1'b0;
         carrier_inc_o <= '0;
      end else begin
         init_ack_o <= init_take;
         if (init_take) begin
            carrier_inc_o <= init_carrier_inc_i;
         end
      end
   end

   // The acknowledge cycle also clears the NCO phase.
   assign restart_o = init_ack_o;

   ////////////////////
   // Period counting
   ////////////////////

   assign period_first = (count_q == '0);
   assign period_last  = (count_q == gps_corr_pkg::count_t'(gps_corr_pkg::ACC_LEN - 1));

   // History holds the two previous chips, newest in bit 0.
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         count_q     <= '0;
         chip_hist_q <= '0;
      end else if (init_take) begin
         count_q     <= '0;
         chip_hist_q <= '0;
      end else if (sample_valid_i) begin
         count_q     <= period_last ? '0 : count_q + 1'b1;
         chip_hist_q <= {chip_hist_q[0], code_chip_i};
      end
   end

   ////////////////////
   // Stage 1
   ////////////////////

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         s1_valid_o <= 1'b0;
         s1_first_o <= 1'b0;
         s1_last_o  <= 1'b0;
      end else begin
         s1_valid_o <= sample_valid_i;
         s1_first_o <= sample_valid_i && period_first;
         s1_last_o  <= sample_valid_i && period_last;
      end
   end

   // Early is the current chip, prompt and late trail by one and two samples.
   always_ff @(posedge clk) begin
      if (sample_valid_i) begin
         s1_sample_o                          <= sample_i;
         s1_chips_o[gps_corr_pkg::TAP_EARLY]  <= code_chip_i;
         s1_chips_o[gps_corr_pkg::TAP_PROMPT] <= chip_hist_q[0];
         s1_chips_o[gps_corr_pkg::TAP_LATE]   <= chip_hist_q[1];
      end
   end

   ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
      init_ack_o |=> !init_ack_o)
      else $error("init_ack_o high for two cycles in a row");

endmodule

`default_nettype wire

// File: logic/gps_corr_pkg.sv
`default_nettype none

package gps_corr_pkg;

   // Input sample from the front end.
   typedef logic signed [2:0] sample_t;

   // Carrier NCO phase and increment, wrapping modulo 2^16.
   typedef logic [15:0] phase_t;

   // Table index taken from the top bits of the phase.
   localparam int LUT_INDEX_BITS = 3;

   typedef logic signed [2:0] carrier_t;

   // One carrier cycle in eight steps.
   localparam carrier_t COS_TABLE [0:7] = '{3, 2, 0, -2, -3, -2, 0, 2};
   localparam carrier_t SIN_TABLE [0:7] = '{0, 2, 3, 2, 0, -2, -3, -2};

   // Sample times carrier value.
   typedef logic signed [5:0] baseband_t;

   // Correlator sums, wrapping on overflow.
   typedef logic signed [15:0] acc_t;

   // Valid samples per accumulation period.
   localparam int ACC_LEN = 16;

   typedef logic [3:0] count_t;

   // Q arm uses the negated sine.
   localparam bit MIXING_SIGN = 1'b1;

   // Correlator taps, used as index into chip and sum arrays.
   typedef enum logic [1:0] {
      TAP_EARLY,
      TAP_PROMPT,
      TAP_LATE
   } tap_e;

   localparam int NUM_TAPS = 3;

endpackage

`default_nettype wire
